//--- filelist.f
+incdir+src
src/pow5_pkg.sv
src/pow5_mode_regs.sv
src/pow5_pipeline.sv
src/pow5_iterative.sv
src/pow5_display_hold.sv
src/pow5_board_top.sv
verification/tb_pow5_board.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator and run it
# a $fatal in the testbench gives a non-zero exit status

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f filelist.f \
    --top-module tb_pow5_board \
    -o sim_pow5 \
    && ./obj_dir/sim_pow5 \
    && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }

//--- verification/tb_pow5_board.sv
`include "pow5_config.svh"

module tb_pow5_board;

    import pow5_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 8;
    localparam logic [31:0] LFSR_SEED = 32'd69208;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // phase lengths in clock cycles
    localparam int PIPE_STEPS    = 64;
    localparam int STALL_STEPS   = 96;
    localparam int DRAIN_STEPS   = 10;
    localparam int MODE_STEPS    = 4;
    localparam int ITER_OPS      = 12;
    localparam int ITER_MAX_GAP  = 9;
    localparam int RESTART_STEPS = 26;
    localparam int BACK_STEPS    = 8;
    localparam int TOTAL_STEPS   = PIPE_STEPS + STALL_STEPS + 3 * DRAIN_STEPS
                                 + 2 * (MODE_STEPS + 1) + ITER_OPS * ITER_MAX_GAP
                                 + RESTART_STEPS + BACK_STEPS;
    localparam int WATCHDOG_TIME = (RESET_CYCLES + TOTAL_STEPS + 50) * CLK_PERIOD;

    // one expected display update stamped in enabled cycles
    typedef struct packed
    {
        int       due;
        int       lane;
        operand_t value;
        logic     from_iter;
    } update_t;

    logic                                clk;
    logic                                rst_n;
    logic                                i_clk_en;
    logic [3:0]                          i_key;
    operand_t                            i_sw;
    logic [`POW5_LANES * `POW5_W - 1:0]  o_disp;
    logic [2 * `POW5_LANES - 1:0]        o_disp_en;
    engine_mode_e                        o_mode;

    logic [31:0]              lfsr_state;
    update_t                  pending [$];
    int                       ecnt;
    int                       clear_due;
    engine_mode_e             model_mode;
    operand_t                 exp_val [`POW5_LANES];
    logic [`POW5_LANES - 1:0] exp_en;
    logic [`POW5_LANES - 1:0] exp_known;

    pow5_board_top UUT
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .i_clk_en  ( i_clk_en  ),
        .i_key     ( i_key     ),
        .i_sw      ( i_sw      ),
        .o_disp    ( o_disp    ),
        .o_disp_en ( o_disp_en ),
        .o_mode    ( o_mode    )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //------------------------------------------------------------
    // random source and power model

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ LFSR_TAPS;
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic random_operand(output operand_t n);
        logic [31:0] r;
        take_bits(`POW5_W, r);
        n = r[`POW5_W - 1:0];
    endtask

    // repeated multiplication wrapping at the operand width
    function automatic operand_t power_of(input operand_t n, input int p);
        operand_t r;
        r = operand_t'(1);
        for (int i = 0; i < p; i++)
            r = r * n;
        return r;
    endfunction

    //------------------------------------------------------------
    // compare tasks

    task automatic check_disp_lane(input string name, input operand_t exp, input operand_t act);
        if (act !== exp)
        begin
            $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "display byte mismatch");
        end
    endtask

    task automatic check_disp_en(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
            $display("Checks failed");
            $fatal(1, "digit enable mismatch");
        end
    endtask

    task automatic check_mode(input string name, input engine_mode_e exp,
                              input engine_mode_e act);
        if (act !== exp)
        begin
            $display("[ERROR] %0t %s expected %s actual %s", $time, name, exp.name(), act.name());
            $display("Checks failed");
            $fatal(1, "mode mismatch");
        end
    endtask

    task automatic check_outputs();
        for (int k = 0; k < `POW5_LANES; k++)
        begin
            // a byte is compared once its value is known
            if (exp_known[k])
                check_disp_lane($sformatf("o_disp[%0d]", k), exp_val[k],
                                operand_t'(o_disp[k * `POW5_W +: `POW5_W]));
            check_disp_en($sformatf("o_disp_en[%0d]", 2 * k), exp_en[k], o_disp_en[2 * k]);
            check_disp_en($sformatf("o_disp_en[%0d]", 2 * k + 1), exp_en[k],
                          o_disp_en[2 * k + 1]);
        end
        check_mode("o_mode", model_mode, o_mode);
    endtask

    //------------------------------------------------------------
    // model advanced on every enabled edge

    task automatic model_edge(input logic [3:0] key, input operand_t sw);
        int      c;
        update_t u;
        ecnt = ecnt + 1;
        c    = ecnt;

        // results landing now from the engine shown
        for (int i = pending.size() - 1; i >= 0; i--)
        begin
            if (pending[i].due == c)
            begin
                if (c != clear_due && pending[i].from_iter == (model_mode == MODE_ITERATIVE))
                begin
                    exp_val[pending[i].lane]   = pending[i].value;
                    exp_en[pending[i].lane]    = 1'b1;
                    exp_known[pending[i].lane] = 1'b1;
                end
                pending.delete(i);
            end
        end
        if (c == clear_due)
        begin
            for (int k = 0; k < `POW5_LANES; k++)
                exp_val[k] = '0;
            exp_en    = '0;
            exp_known = '1;
        end

        // operand strobe goes to the engine selected before this edge
        if (key[0] && model_mode == MODE_PIPELINED)
        begin
            for (int k = 0; k < `POW5_LANES; k++)
            begin
                u.due       = c + `POW5_LANES + 1 - k;
                u.lane      = k;
                u.value     = power_of(sw, `POW5_LANES + 1 - k);
                u.from_iter = 1'b0;
                pending.push_back(u);
            end
        end
        else if (key[0])
        begin
            // unfinished iterative result is abandoned
            for (int i = pending.size() - 1; i >= 0; i--)
                if (pending[i].from_iter && pending[i].due > c + 1)
                    pending.delete(i);
            u.due       = c + `POW5_LANES + 2;
            u.lane      = 0;
            u.value     = power_of(sw, `POW5_LANES + 1);
            u.from_iter = 1'b1;
            pending.push_back(u);
        end

        if (key[1])
        begin
            model_mode = engine_mode_e'(sw[0]);
            clear_due  = c + 1;
        end
    endtask

    // one clock cycle entered just after a rising edge
    task automatic step(input logic en, input logic [3:0] key, input operand_t sw);
        i_clk_en = en;
        i_key    = key;
        i_sw     = sw;
        @(posedge clk);
        if (en)
            model_edge(key, sw);
        #(DRIVE_DELAY);
        check_outputs();
    endtask

    //------------------------------------------------------------
    // stimulus

    initial
    begin
        logic [31:0] r;
        operand_t    n;
        int          gap;
        clk        = 1'b0;
        rst_n      = 1'b0;
        i_clk_en   = 1'b0;
        i_key      = '0;
        i_sw       = '0;
        lfsr_state = LFSR_SEED;
        ecnt       = 0;
        clear_due  = -1;
        model_mode = MODE_PIPELINED;
        exp_en     = '0;
        exp_known  = '0;
        for (int k = 0; k < `POW5_LANES; k++)
            exp_val[k] = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        check_outputs();

        // pipelined traffic including back-to-back strobes
        for (int i = 0; i < PIPE_STEPS; i++)
        begin
            take_bits(1, r);
            random_operand(n);
            step(1'b1, {3'b000, r[0]}, n);
        end
        repeat (DRAIN_STEPS) step(1'b1, 4'b0000, '0);

        // same traffic with the clock enable dropping now and then
        for (int i = 0; i < STALL_STEPS; i++)
        begin
            take_bits(2, r);
            gap = int'(r[1:0]);
            take_bits(1, r);
            random_operand(n);
            step(gap != 0, {3'b000, r[0]}, n);
        end
        repeat (DRAIN_STEPS) step(1'b1, 4'b0000, '0);

        // this strobe must not reach the iterative engine
        random_operand(n);
        step(1'b1, 4'b0001, n);

        // switch to the iterative engine
        step(1'b1, 4'b0010, operand_t'(1));
        repeat (MODE_STEPS - 1) step(1'b1, 4'b0000, '0);

        for (int i = 0; i < ITER_OPS; i++)
        begin
            take_bits(2, r);
            gap = 6 + int'(r[1:0]);
            random_operand(n);
            step(1'b1, 4'b0001, n);
            repeat (gap - 1) step(1'b1, 4'b0000, '0);
        end

        // second strobe lands before the first result
        for (int g = 2; g <= 4; g += 2)
        begin
            random_operand(n);
            step(1'b1, 4'b0001, n);
            repeat (g - 1) step(1'b1, 4'b0000, '0);
            random_operand(n);
            step(1'b1, 4'b0001, n);
            repeat (8) step(1'b1, 4'b0000, '0);
        end

        // this strobe must not reach the pipeline
        random_operand(n);
        step(1'b1, 4'b0001, n);

        // back to the pipeline where the first step always strobes
        step(1'b1, 4'b0010, operand_t'(0));
        repeat (MODE_STEPS - 1) step(1'b1, 4'b0000, '0);
        for (int i = 0; i < BACK_STEPS; i++)
        begin
            take_bits(1, r);
            random_operand(n);
            step(1'b1, {3'b000, r[0] | (i == 0)}, n);
        end
        repeat (DRAIN_STEPS) step(1'b1, 4'b0000, '0);

        if (pending.size() != 0 || exp_en != '1)
        begin
            $display("expected results did not all reach the display");
            $display("Checks failed");
            $fatal(1, "results missing at end of run");
        end
        else
        begin
            $display("All checks passed");
            $finish;
        end
    end

    // watchdog
    initial
    begin
        #(WATCHDOG_TIME);
        $display("simulation ran past its time limit of %0d cycles", WATCHDOG_TIME / CLK_PERIOD);
        $display("Checks failed");
        $fatal(1, "timeout");
    end

endmodule

//--- src/pow5_board_top.sv
`include "pow5_config.svh"

module pow5_board_top
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  i_clk_en,
    input  logic [3:0]                            i_key,
    input  pow5_pkg::operand_t                    i_sw,
    output logic [`POW5_LANES * `POW5_W - 1:0]    o_disp,
    output logic [2 * `POW5_LANES - 1:0]          o_disp_en,
    output pow5_pkg::engine_mode_e                o_mode
);

    import pow5_pkg::*;

    mode_cfg_t cfg;
    logic      pipe_start;
    logic      iter_start;
    lanes_t    pipe_lanes;
    lane_t     iter_lane;
    lanes_t    iter_lanes;

    //------------------------------------------------------------
    // key 1 writes the mode from switch 0, key 0 strobes the operand

    pow5_mode_regs u_mode_regs
    (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .i_clk_en     ( i_clk_en   ),
        .i_mode_wr    ( i_key[1]   ),
        .i_mode_val   ( i_sw[0]    ),
        .i_start      ( i_key[0]   ),
        .o_cfg        ( cfg        ),
        .o_pipe_start ( pipe_start ),
        .o_iter_start ( iter_start )
    );

    pow5_pipeline u_pipeline
    (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .i_clk_en ( i_clk_en   ),
        .i_start  ( pipe_start ),
        .i_n      ( i_sw       ),
        .o_lanes  ( pipe_lanes )
    );

    pow5_iterative u_iterative
    (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .i_clk_en ( i_clk_en   ),
        .i_start  ( iter_start ),
        .i_n      ( i_sw       ),
        .o_lane   ( iter_lane  )
    );

    // iterative engine only fills lane 0
    always_comb
    begin
        iter_lanes    = '0;
        iter_lanes[0] = iter_lane;
    end

    pow5_display_hold u_display_hold
    (
        .clk          ( clk        ),
        .rst_n        ( rst_n      ),
        .i_clk_en     ( i_clk_en   ),
        .i_cfg        ( cfg        ),
        .i_pipe_lanes ( pipe_lanes ),
        .i_iter_lanes ( iter_lanes ),
        .o_disp       ( o_disp     ),
        .o_disp_en    ( o_disp_en  )
    );

    assign o_mode = cfg.mode;

endmodule

//--- src/pow5_display_hold.sv
`include "pow5_config.svh"

module pow5_display_hold
(
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  i_clk_en,
    input  pow5_pkg::mode_cfg_t                   i_cfg,
    input  pow5_pkg::lanes_t                      i_pipe_lanes,
    input  pow5_pkg::lanes_t                      i_iter_lanes,
    output logic [`POW5_LANES * `POW5_W - 1:0]    o_disp,
    output logic [2 * `POW5_LANES - 1:0]          o_disp_en
);

    import pow5_pkg::*;

    lanes_t                  sel_lanes;
    operand_t                hold_q [`POW5_LANES];
    logic [`POW5_LANES - 1:0] shown_q;

    //------------------------------------------------------------
    // lane set of the active engine

    always_comb
    begin
        if (i_cfg.mode == MODE_PIPELINED)
            sel_lanes = i_pipe_lanes;
        else
            sel_lanes = i_iter_lanes;
    end

    //------------------------------------------------------------
    // shown flags, cleared on a mode change

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shown_q <= '0;
        end
        else if (i_clk_en)
        begin
            for (int k = 0; k < `POW5_LANES; k++)
            begin
                if (i_cfg.clear)
                    shown_q[k] <= 1'b0;
                else if (sel_lanes[k].vld)
                    shown_q[k] <= 1'b1;
            end
        end
    end

    //------------------------------------------------------------
    // holding bytes, replaced on each valid

    always_ff @(posedge clk)
    begin
        if (i_clk_en)
        begin
            for (int k = 0; k < `POW5_LANES; k++)
            begin
                if (i_cfg.clear)
                    hold_q[k] <= '0;
                else if (sel_lanes[k].vld)
                    hold_q[k] <= sel_lanes[k].value;
            end
        end
    end

    //------------------------------------------------------------
    // outputs, lane k in byte k

    always_comb
    begin
        for (int k = 0; k < `POW5_LANES; k++)
        begin
            o_disp[k * `POW5_W +: `POW5_W] = hold_q[k];
        end
    end

    // two digits per lane, both follow the flag
    always_comb
    begin
        for (int k = 0; k < `POW5_LANES; k++)
        begin
            o_disp_en[2 * k]     = shown_q[k];
            o_disp_en[2 * k + 1] = shown_q[k];
        end
    end

endmodule

//--- src/pow5_iterative.sv
`include "pow5_config.svh"

module pow5_iterative
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_clk_en,
    input  logic               i_start,
    input  pow5_pkg::operand_t i_n,
    output pow5_pkg::lane_t    o_lane
);

    import pow5_pkg::*;

    logic                   start_q;
    operand_t               n_q;
    logic [`POW5_DEPTH - 1:0] shift_q;
    operand_t               acc_q;
    logic                   mul_en;

    //------------------------------------------------------------
    // input capture

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            start_q <= 1'b0;
        end
        else if (i_clk_en)
        begin
            start_q <= i_start;
        end
    end

    // operand is held for the whole computation
    always_ff @(posedge clk)
    begin
        if (i_clk_en && i_start)
        begin
            n_q <= i_n;
        end
    end

    //------------------------------------------------------------
    // one-hot step shifter, a new start restarts it

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shift_q <= '0;
        end
        else if (i_clk_en)
        begin
            if (start_q)
                shift_q <= {1'b1, {(`POW5_DEPTH - 1){1'b0}}};
            else
                shift_q <= shift_q >> 1;
        end
    end

    //------------------------------------------------------------
    // shared multiplier, idle once the last step is done

    assign mul_en = i_clk_en && (start_q || (|shift_q[`POW5_DEPTH - 1:1]));

    always_ff @(posedge clk)
    begin
        if (mul_en)
        begin
            if (start_q)
                acc_q <= n_q;
            else
                acc_q <= acc_q * n_q;
        end
    end

    assign o_lane.vld   = shift_q[0];
    assign o_lane.value = acc_q;

endmodule

//--- src/pow5_pipeline.sv
`include "pow5_config.svh"

module pow5_pipeline
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               i_clk_en,
    input  logic               i_start,
    input  pow5_pkg::operand_t i_n,
    output pow5_pkg::lanes_t   o_lanes
);

    import pow5_pkg::*;

    // bit i is the strobe for the operand sitting in stage i
    logic [`POW5_DEPTH:1] vld_q;

    // operand copies travel with the partial powers
    operand_t n_q   [1:`POW5_DEPTH - 1];
    operand_t pow_q [2:`POW5_DEPTH];

    //------------------------------------------------------------
    // valid chain

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vld_q <= '0;
        end
        else if (i_clk_en)
        begin
            vld_q <= {vld_q[`POW5_DEPTH - 1:1], i_start};
        end
    end

    //------------------------------------------------------------
    // operand delay line and multiplier stages

    always_ff @(posedge clk)
    begin
        if (i_clk_en)
        begin
            n_q[1] <= i_n;

            for (int i = 1; i < `POW5_DEPTH - 1; i++)
            begin
                n_q[i + 1] <= n_q[i];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_clk_en)
        begin
            // first stage squares, the rest multiply by the delayed operand
            pow_q[2] <= n_q[1] * n_q[1];

            for (int i = 2; i < `POW5_DEPTH; i++)
            begin
                pow_q[i + 1] <= pow_q[i] * n_q[i];
            end
        end
    end

    //------------------------------------------------------------
    // every stage reports its power, n^5 lands in lane 0

    always_comb
    begin
        for (int i = 2; i <= `POW5_DEPTH; i++)
        begin
            o_lanes[`POW5_DEPTH - i].vld   = vld_q[i];
            o_lanes[`POW5_DEPTH - i].value = pow_q[i];
        end
    end

endmodule

//--- src/pow5_mode_regs.sv
module pow5_mode_regs
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                i_clk_en,
    input  logic                i_mode_wr,
    input  logic                i_mode_val,
    input  logic                i_start,
    output pow5_pkg::mode_cfg_t o_cfg,
    output logic                o_pipe_start,
    output logic                o_iter_start
);

    import pow5_pkg::*;

    engine_mode_e mode_q;
    logic         clear_q;

    //------------------------------------------------------------
    // mode register, written from the switches

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mode_q <= MODE_PIPELINED;
        end
        else if (i_clk_en && i_mode_wr)
        begin
            mode_q <= engine_mode_e'(i_mode_val);
        end
    end

    // clear pulse follows every write
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            clear_q <= 1'b0;
        end
        else if (i_clk_en)
        begin
            clear_q <= i_mode_wr;
        end
    end

    assign o_cfg.mode  = mode_q;
    assign o_cfg.clear = clear_q;

    //------------------------------------------------------------
    // strobe goes only to the selected engine

    assign o_pipe_start = i_start && (mode_q == MODE_PIPELINED);
    assign o_iter_start = i_start && (mode_q == MODE_ITERATIVE);

endmodule

//--- src/pow5_pkg.sv
`include "pow5_config.svh"

package pow5_pkg;

    //------------------------------------------------------------
    // operand and result word

    typedef logic [`POW5_W - 1:0] operand_t;

    //------------------------------------------------------------
    // engine selection

    typedef enum logic
    {
        MODE_PIPELINED = 1'b0,
        MODE_ITERATIVE = 1'b1
    } engine_mode_e;

    //------------------------------------------------------------
    // one reported power with its strobe

    typedef struct packed
    {
        logic     vld;
        operand_t value;
    } lane_t;

    // index 0 is n^5, index 3 is n^2
    typedef lane_t [`POW5_LANES - 1:0] lanes_t;

    //------------------------------------------------------------
    // mode register contents

    typedef struct packed
    {
        engine_mode_e mode;
        logic         clear;  // one enabled cycle after a mode write
    } mode_cfg_t;

endpackage

//--- src/pow5_config.svh
`ifndef POW5_CONFIG_SVH
`define POW5_CONFIG_SVH

// operand and result width, products wrap at this width
`define POW5_W      8

// reported powers n^2 .. n^5
`define POW5_LANES  4

// stages in the power chain, one more than the lanes
`define POW5_DEPTH  (`POW5_LANES + 1)

`endif
